// ==== Makefile ====
SOURCES = $(wildcard src/*.sv testbench/*.sv testbench/*.svh)

.PHONY: all run clean

all: run

obj_dir/VballPhysicsTb: vlog.f $(SOURCES)
	verilator --binary --timing -Wno-fatal --top-module ballPhysicsTb -f vlog.f

run: obj_dir/VballPhysicsTb
	./obj_dir/VballPhysicsTb | tee sim.log
	@if grep -q "FAIL: see errors above" sim.log; then exit 1; fi
	@grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== src/ballDrawMux.sv ====
`timescale 1ns/10ps

module ballDrawMux (
	input logic clk,
	input logic resetN,
	input gamePkg::pixelCoord pixel,
	input gamePkg::ballPosition [gamePkg::NUM_BALLS-1:0] positions,
	output logic drawBall,
	output logic [1:0] drawIndex,
	output logic [gamePkg::NUM_BALLS-1:0] ballLost
);

	int pixelX;
	int pixelY;
	logic [gamePkg::NUM_BALLS-1:0] covered;
	logic [1:0] winnerIndex;

	assign pixelX = int'(pixel.pixelX);
	assign pixelY = int'(pixel.pixelY);

	// a ball may sit partly off screen, so the corner is compared as a signed value.
	always_comb begin
		int ballX;
		int ballY;
		for (int i = 0; i < gamePkg::NUM_BALLS; i++) begin
			ballX = int'($signed(positions[i].topLeftX));
			ballY = int'($signed(positions[i].topLeftY));
			covered[i] = (pixelX >= ballX) && (pixelX < ballX + gamePkg::BALL_SIZE)
				&& (pixelY >= ballY) && (pixelY < ballY + gamePkg::BALL_SIZE);
		end
	end

	// scanning downward lets the lowest covering index overwrite the others.
	always_comb begin
		winnerIndex = '0;
		for (int i = gamePkg::NUM_BALLS - 1; i >= 0; i--) begin
			if (covered[i]) begin
				winnerIndex = 2'(i);
			end
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			drawBall <= 1'b0;
			drawIndex <= '0;
		end else begin
			drawBall <= |covered;
			drawIndex <= winnerIndex;
		end
	end

	always_comb begin
		for (int i = 0; i < gamePkg::NUM_BALLS; i++) begin
			ballLost[i] = int'($signed(positions[i].topLeftY)) > gamePkg::SCREEN_BOTTOM;
		end
	end

endmodule

// ==== src/ballMotion.sv ====
`timescale 1ns/10ps

module ballMotion (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic pause,
	input logic levelReset,
	input collisionPkg::ballCollision collision,
	input int flipperSpeedX,
	input int springSpeedY,
	input gamePkg::ballPosition initialPosition,
	output gamePkg::ballPosition position
);

	int xSpeed;
	int ySpeed;
	int xFixed;
	int yFixed;
	int initXFixed;
	int initYFixed;
	int bumperSpeedX;
	int bumperSpeedY;
	logic [gamePkg::COOLDOWN_WIDTH-1:0] cooldown;

	assign initXFixed = int'(initialPosition.topLeftX) * gamePkg::FIXED_POINT_MULTIPLIER;
	assign initYFixed = int'(initialPosition.topLeftY) * gamePkg::FIXED_POINT_MULTIPLIER;

	// both new speeds are computed from the old pair of speeds.
	always_comb begin
		bumperSpeedX = (xSpeed * $signed(collision.factor.xxFactor)
			+ ySpeed * $signed(collision.factor.yxFactor)) >>> 1;
		bumperSpeedY = (ySpeed * $signed(collision.factor.yyFactor)
			+ xSpeed * $signed(collision.factor.xyFactor)) >>> 1;
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			xSpeed <= 0;
			ySpeed <= 0;
			xFixed <= initXFixed;
			yFixed <= initYFixed;
			cooldown <= '0;
		end else if (levelReset) begin
			xSpeed <= 0;
			ySpeed <= 0;
			xFixed <= initXFixed;
			yFixed <= initYFixed;
			cooldown <= '0;
		end else if (!pause) begin
			if (startOfFrame) begin
				// the frame step uses the old speed, so gravity shows up one frame later.
				xFixed <= xFixed + xSpeed;
				yFixed <= yFixed + ySpeed;
				ySpeed <= ySpeed + gamePkg::GRAVITY;
				if (cooldown != '0) begin
					cooldown <= cooldown - 1'b1;
				end
			end else if (collision.strobe) begin
				case (collision.source)
					collisionPkg::FRAME,
					collisionPkg::OBSTACLE: begin
						// only a speed heading into the touched edge is turned around.
						if (collision.edges.left && (xSpeed < 0)) begin
							xSpeed <= -xSpeed;
						end else if (collision.edges.right && (xSpeed > 0)) begin
							xSpeed <= -xSpeed;
						end
						if (collision.edges.top && (ySpeed < 0)) begin
							ySpeed <= -ySpeed;
						end else if (collision.edges.bottom && (ySpeed > 0)) begin
							ySpeed <= -ySpeed;
						end
					end
					collisionPkg::SPRING: begin
						if (collision.edges.bottom) begin
							if (springSpeedY < 0) begin
								ySpeed <= ySpeed + springSpeedY;
							end else begin
								ySpeed <= -ySpeed;
							end
						end
					end
					collisionPkg::FLIPPER: begin
						if (collision.edges.bottom && (ySpeed > 0)) begin
							ySpeed <= -ySpeed;
							xSpeed <= xSpeed + flipperSpeedX;
						end
					end
					collisionPkg::BUMPER: begin
						// a ball still inside the bumper must not be deflected again.
						if (cooldown == '0) begin
							xSpeed <= bumperSpeedX;
							ySpeed <= bumperSpeedY;
							cooldown <= gamePkg::COOLDOWN_WIDTH'(gamePkg::BUMPER_COOLDOWN);
						end
					end
					default: begin
					end
				endcase
			end
		end
	end

	assign position.topLeftX = 11'(xFixed / gamePkg::FIXED_POINT_MULTIPLIER);
	assign position.topLeftY = 11'(yFixed / gamePkg::FIXED_POINT_MULTIPLIER);

endmodule

// ==== src/ballPhysicsTop.sv ====
`timescale 1ns/10ps

module ballPhysicsTop (
	input logic clk,
	input logic resetN,
	input logic startOfFrame,
	input logic pause,
	input logic levelReset,
	input collisionPkg::hitEvent hit,
	input int flipperSpeedX,
	input int springSpeedY,
	input gamePkg::pixelCoord pixel,
	output gamePkg::ballPosition [gamePkg::NUM_BALLS-1:0] positions,
	output logic drawBall,
	output logic [1:0] drawIndex,
	output logic [gamePkg::NUM_BALLS-1:0] ballLost
);

	collisionPkg::ballCollision [gamePkg::NUM_BALLS-1:0] collisions;
	int routedFlipperSpeedX;
	int routedSpringSpeedY;

	collisionRouter u_collisionRouter (
		.clk(clk),
		.resetN(resetN),
		.hit(hit),
		.flipperSpeedXIn(flipperSpeedX),
		.springSpeedYIn(springSpeedY),
		.collisions(collisions),
		.flipperSpeedX(routedFlipperSpeedX),
		.springSpeedY(routedSpringSpeedY)
	);

	for (genvar i = 0; i < gamePkg::NUM_BALLS; i++) begin : gBall
		gamePkg::ballPosition startCorner;

		// balls start side by side along the top of the playfield.
		assign startCorner.topLeftX = 11'(gamePkg::BALL_INIT_X + gamePkg::BALL_INIT_X_STEP * i);
		assign startCorner.topLeftY = 11'(gamePkg::BALL_INIT_Y);

		ballMotion u_ballMotion (
			.clk(clk),
			.resetN(resetN),
			.startOfFrame(startOfFrame),
			.pause(pause),
			.levelReset(levelReset),
			.collision(collisions[i]),
			.flipperSpeedX(routedFlipperSpeedX),
			.springSpeedY(routedSpringSpeedY),
			.initialPosition(startCorner),
			.position(positions[i])
		);
	end

	ballDrawMux u_ballDrawMux (
		.clk(clk),
		.resetN(resetN),
		.pixel(pixel),
		.positions(positions),
		.drawBall(drawBall),
		.drawIndex(drawIndex),
		.ballLost(ballLost)
	);

endmodule

// ==== src/collisionPkg.sv ====
package collisionPkg;

	typedef enum logic [2:0] {
		NONE,
		FRAME,
		OBSTACLE,
		SPRING,
		FLIPPER,
		BUMPER
	} collisionSource;

	// left is the most significant bit, as the video collision logic reports it.
	typedef struct packed {
		logic left;
		logic top;
		logic right;
		logic bottom;
	} edgeCode;

	// new speeds are (X*xx + Y*yx) >>> 1 and (Y*yy + X*xy) >>> 1.
	typedef struct packed {
		logic signed [3:0] xxFactor;
		logic signed [3:0] xyFactor;
		logic signed [3:0] yxFactor;
		logic signed [3:0] yyFactor;
	} collisionFactor;

	localparam int NUM_BUMPERS = 4;

	// bumper 0 reflects straight back, bumper 1 swaps the axes, the others skew the path.
	localparam collisionFactor BUMPER_FACTORS [NUM_BUMPERS] = '{
		'{xxFactor: -4'sd2, xyFactor: 4'sd0, yxFactor: 4'sd0, yyFactor: -4'sd2},
		'{xxFactor: 4'sd0, xyFactor: -4'sd2, yxFactor: -4'sd2, yyFactor: 4'sd0},
		'{xxFactor: -4'sd1, xyFactor: 4'sd1, yxFactor: 4'sd1, yyFactor: -4'sd2},
		'{xxFactor: 4'sd2, xyFactor: -4'sd1, yxFactor: -4'sd1, yyFactor: -4'sd2}
	};

	typedef struct packed {
		logic valid;
		logic [1:0] ballIndex;
		collisionSource source;
		edgeCode edges;
		logic [1:0] bumperIndex;
	} hitEvent;

	typedef struct packed {
		logic strobe;
		collisionSource source;
		edgeCode edges;
		collisionFactor factor;
	} ballCollision;

endpackage

// ==== src/collisionRouter.sv ====
`timescale 1ns/10ps

module collisionRouter (
	input logic clk,
	input logic resetN,
	input collisionPkg::hitEvent hit,
	input int flipperSpeedXIn,
	input int springSpeedYIn,
	output collisionPkg::ballCollision [gamePkg::NUM_BALLS-1:0] collisions,
	output int flipperSpeedX,
	output int springSpeedY
);

	logic [gamePkg::NUM_BALLS-1:0] strobeReg;
	collisionPkg::collisionSource eventSource;
	collisionPkg::edgeCode eventEdges;
	collisionPkg::collisionFactor eventFactor;
	collisionPkg::collisionFactor selectedFactor;

	// only bumpers deflect through the factor table.
	always_comb begin
		if (hit.source == collisionPkg::BUMPER) begin
			selectedFactor = collisionPkg::BUMPER_FACTORS[hit.bumperIndex];
		end else begin
			selectedFactor = '0;
		end
	end

	// one-hot strobe toward the addressed ball; an index past the last ball is dropped.
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			strobeReg <= '0;
		end else begin
			for (int i = 0; i < gamePkg::NUM_BALLS; i++) begin
				strobeReg[i] <= hit.valid && (hit.ballIndex == 2'(i));
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hit.valid) begin
			eventSource <= hit.source;
			eventEdges <= hit.edges;
			eventFactor <= selectedFactor;
			flipperSpeedX <= flipperSpeedXIn;
			springSpeedY <= springSpeedYIn;
		end
	end

	// the event body is shared, only the strobe tells the balls apart.
	always_comb begin
		for (int i = 0; i < gamePkg::NUM_BALLS; i++) begin
			collisions[i].strobe = strobeReg[i];
			collisions[i].source = eventSource;
			collisions[i].edges = eventEdges;
			collisions[i].factor = eventFactor;
		end
	end

endmodule

// ==== src/gamePkg.sv ====
package gamePkg;

	// number of balls in play, one motion block each.
	localparam int NUM_BALLS = 3;

	// positions and speeds carry six fraction bits.
	localparam int FIXED_POINT_MULTIPLIER = 64;

	// Y speed gained on every frame, in fixed-point units.
	localparam int GRAVITY = 8;

	// start corner of ball 0; each further ball starts BALL_INIT_X_STEP pixels to the right.
	localparam int BALL_INIT_X = 100;
	localparam int BALL_INIT_X_STEP = 40;
	localparam int BALL_INIT_Y = 50;

	localparam int BALL_SIZE = 16;

	// a ball whose top edge passes this line has left the playfield.
	localparam int SCREEN_BOTTOM = 479;

	localparam int BUMPER_COOLDOWN = 10;
	localparam int COOLDOWN_WIDTH = $clog2(BUMPER_COOLDOWN + 1);

	typedef struct packed {
		logic signed [10:0] topLeftX;
		logic signed [10:0] topLeftY;
	} ballPosition;

	typedef struct packed {
		logic [10:0] pixelX;
		logic [10:0] pixelY;
	} pixelCoord;

endpackage

// ==== testbench/ballPhysicsTests.svh ====
localparam logic [3:0] EDGE_TOP = 4'b0100;
localparam logic [3:0] EDGE_BOTTOM = 4'b0001;
localparam logic [3:0] NO_EDGES = 4'b0000;

// fixed-point state of every ball as the physics rules predict it.
int refX [gamePkg::NUM_BALLS];
int refY [gamePkg::NUM_BALLS];
int refSpeedX [gamePkg::NUM_BALLS];
int refSpeedY [gamePkg::NUM_BALLS];
int refCooldown [gamePkg::NUM_BALLS];

function automatic void resetModel();
	for (int b = 0; b < gamePkg::NUM_BALLS; b++) begin
		refX[b] = (gamePkg::BALL_INIT_X + gamePkg::BALL_INIT_X_STEP * b) * SCALE;
		refY[b] = gamePkg::BALL_INIT_Y * SCALE;
		refSpeedX[b] = 0;
		refSpeedY[b] = 0;
		refCooldown[b] = 0;
	end
endfunction

function automatic void advanceModelFrame();
	for (int b = 0; b < gamePkg::NUM_BALLS; b++) begin
		refX[b] += refSpeedX[b];
		refY[b] += refSpeedY[b];
		refSpeedY[b] += gamePkg::GRAVITY;
		if (refCooldown[b] > 0) begin
			refCooldown[b]--;
		end
	end
endfunction

function automatic void applyModelHit(input int ball, input collisionPkg::collisionSource source,
		input logic [3:0] edgeBits, input int bumper);
	collisionPkg::edgeCode touched;
	collisionPkg::collisionFactor f;
	int oldX;
	int oldY;
	touched = collisionPkg::edgeCode'(edgeBits);
	f = collisionPkg::BUMPER_FACTORS[bumper];
	oldX = refSpeedX[ball];
	oldY = refSpeedY[ball];
	case (source)
		collisionPkg::FRAME, collisionPkg::OBSTACLE: begin
			if ((touched.left && oldX < 0) || (touched.right && oldX > 0)) begin
				refSpeedX[ball] = -oldX;
			end
			if ((touched.top && oldY < 0) || (touched.bottom && oldY > 0)) begin
				refSpeedY[ball] = -oldY;
			end
		end
		collisionPkg::SPRING: begin
			if (touched.bottom) begin
				refSpeedY[ball] = (springSpeedY < 0) ? oldY + springSpeedY : -oldY;
			end
		end
		collisionPkg::FLIPPER: begin
			if (touched.bottom && oldY > 0) begin
				refSpeedY[ball] = -oldY;
				refSpeedX[ball] = oldX + flipperSpeedX;
			end
		end
		collisionPkg::BUMPER: begin
			if (refCooldown[ball] == 0) begin
				refSpeedX[ball] = (oldX * int'(f.xxFactor) + oldY * int'(f.yxFactor)) >>> 1;
				refSpeedY[ball] = (oldY * int'(f.yyFactor) + oldX * int'(f.xyFactor)) >>> 1;
				refCooldown[ball] = gamePkg::BUMPER_COOLDOWN;
			end
		end
		default: begin
		end
	endcase
endfunction

task automatic comparePositions();
	logic [gamePkg::NUM_BALLS-1:0] lostExpect;
	for (int b = 0; b < gamePkg::NUM_BALLS; b++) begin
		checkValue($sformatf("ball %0d x", b), refX[b] / SCALE,
			int'(positions[b].topLeftX));
		checkValue($sformatf("ball %0d y", b), refY[b] / SCALE,
			int'(positions[b].topLeftY));
		lostExpect[b] = (refY[b] / SCALE) > gamePkg::SCREEN_BOTTOM;
	end
	checkValue("ballLost", int'(lostExpect), int'(ballLost));
endtask

// one frame is a single-cycle startOfFrame pulse and a few idle cycles.
task automatic stepFrames(input int count);
	repeat (count) begin
		startOfFrame = 1'b1;
		waitCycles(1);
		startOfFrame = 1'b0;
		waitCycles(FRAME_IDLE);
		if (!pause) begin
			advanceModelFrame();
		end
		comparePositions();
	end
endtask

task automatic sendHit(input int ball, input collisionPkg::collisionSource source,
		input logic [3:0] edgeBits, input int bumper);
	hit.valid = 1'b1;
	hit.ballIndex = 2'(ball);
	hit.source = source;
	hit.edges = collisionPkg::edgeCode'(edgeBits);
	hit.bumperIndex = 2'(bumper);
	waitCycles(1);
	hit = '0;
	// one cycle in the router, one more for the speed register.
	waitCycles(2);
	if (!pause) begin
		applyModelHit(ball, source, edgeBits, bumper);
	end
endtask

task automatic applyLevelReset();
	levelReset = 1'b1;
	waitCycles(2);
	levelReset = 1'b0;
	resetModel();
	comparePositions();
endtask

task automatic probePixel(input int px, input int py);
	logic covered;
	int winner;
	pixel.pixelX = 11'(px);
	pixel.pixelY = 11'(py);
	waitCycles(1);
	winner = -1;
	for (int b = 0; b < gamePkg::NUM_BALLS; b++) begin
		covered = px >= refX[b] / SCALE && px < refX[b] / SCALE + gamePkg::BALL_SIZE
			&& py >= refY[b] / SCALE && py < refY[b] / SCALE + gamePkg::BALL_SIZE;
		if (covered && winner < 0) begin
			winner = b;
		end
	end
	checkValue($sformatf("drawBall at %0d,%0d", px, py), int'(winner >= 0), int'(drawBall));
	if (winner >= 0) begin
		checkValue($sformatf("drawIndex at %0d,%0d", px, py), winner, int'(drawIndex));
	end
endtask

task automatic freeFallAndReset();
	int expectY;
	beginTest("free fall and reset state");
	comparePositions();
	checkValue("drawBall after reset", 0, int'(drawBall));
	for (int k = 1; k <= 10; k++) begin
		stepFrames(1);
		// the gravity sum starts at zero because the first frame still moves with zero speed.
		expectY = gamePkg::BALL_INIT_Y * SCALE + gamePkg::GRAVITY * k * (k - 1) / 2;
		for (int b = 0; b < gamePkg::NUM_BALLS; b++) begin
			checkValue($sformatf("ball %0d y after %0d frames", b, k), expectY / SCALE,
				int'(positions[b].topLeftY));
		end
	end
	endTest();
endtask

task automatic edgeReflection();
	beginTest("edge reflection");
	applyLevelReset();
	stepFrames(4);
	sendHit(1, collisionPkg::FRAME, EDGE_BOTTOM, 0);
	stepFrames(3);
	// ball 0 falls away from the top edge, so its speed stays.
	sendHit(0, collisionPkg::FRAME, EDGE_TOP, 0);
	stepFrames(2);
	endTest();
endtask

task automatic springAndFlipper();
	beginTest("spring and flipper");
	applyLevelReset();
	stepFrames(3);
	springSpeedY = -200;
	sendHit(2, collisionPkg::SPRING, EDGE_BOTTOM, 0);
	springSpeedY = 50;
	sendHit(1, collisionPkg::SPRING, EDGE_BOTTOM, 0);
	stepFrames(4);
	flipperSpeedX = 96;
	sendHit(0, collisionPkg::FLIPPER, EDGE_BOTTOM, 0);
	sendHit(2, collisionPkg::FLIPPER, EDGE_BOTTOM, 0);
	stepFrames(3);
	endTest();
endtask

task automatic bumperCooldown();
	beginTest("bumper and cooldown");
	applyLevelReset();
	stepFrames(2);
	flipperSpeedX = 64;
	sendHit(1, collisionPkg::FLIPPER, EDGE_BOTTOM, 0);
	stepFrames(1);
	sendHit(1, collisionPkg::BUMPER, NO_EDGES, 2);
	stepFrames(3);
	sendHit(1, collisionPkg::BUMPER, NO_EDGES, 3);
	stepFrames(7);
	sendHit(1, collisionPkg::BUMPER, NO_EDGES, 0);
	stepFrames(2);
	endTest();
endtask

task automatic pauseAndLevelReset();
	beginTest("pause and level reset");
	applyLevelReset();
	stepFrames(3);
	pause = 1'b1;
	stepFrames(3);
	flipperSpeedX = 50;
	sendHit(0, collisionPkg::FLIPPER, EDGE_BOTTOM, 0);
	stepFrames(1);
	pause = 1'b0;
	stepFrames(2);
	applyLevelReset();
	// zero speed after the reset keeps every ball in place for one frame.
	stepFrames(1);
	endTest();
endtask

task automatic drawAndLostFlag();
	int frames;
	beginTest("draw mux and lost flag");
	applyLevelReset();
	probePixel(105, 55);
	probePixel(145, 60);
	probePixel(185, 55);
	stepFrames(1);
	flipperSpeedX = -30 * SCALE;
	sendHit(1, collisionPkg::FLIPPER, EDGE_BOTTOM, 0);
	stepFrames(1);
	// ball 1 has slid onto ball 0 and the first pixel lies in both.
	probePixel(112, 55);
	probePixel(125, 55);
	probePixel(300, 300);
	applyLevelReset();
	springSpeedY = -200;
	sendHit(2, collisionPkg::SPRING, EDGE_BOTTOM, 0);
	frames = 0;
	while ((refY[0] / SCALE) <= gamePkg::SCREEN_BOTTOM && frames < 120) begin
		stepFrames(1);
		frames++;
	end
	checkValue("ball 0 lost", 1, int'(ballLost[0]));
	checkValue("ball 2 lost", 0, int'(ballLost[2]));
	endTest();
endtask

// ==== testbench/ballPhysicsTb.sv ====
`timescale 1ns/10ps

module ballPhysicsTb;

	localparam int CLK_PERIOD = 4;
	localparam int FRAME_IDLE = 2;
	localparam int SCALE = gamePkg::FIXED_POINT_MULTIPLIER;
	// the six tests step about 140 frames, most of them while a ball falls out of the playfield.
	localparam int TEST_FRAMES = 140;
	localparam int WATCHDOG_CYCLES = 2 * TEST_FRAMES * (FRAME_IDLE + 1) + 600;

	logic clk;
	logic resetN;
	logic startOfFrame;
	logic pause;
	logic levelReset;
	collisionPkg::hitEvent hit;
	int flipperSpeedX;
	int springSpeedY;
	gamePkg::pixelCoord pixel;
	gamePkg::ballPosition [gamePkg::NUM_BALLS-1:0] positions;
	logic drawBall;
	logic [1:0] drawIndex;
	logic [gamePkg::NUM_BALLS-1:0] ballLost;

	int errorCount = 0;
	int checkCount = 0;
	int testCount = 0;
	int testErrorStart = 0;
	string testName = "";

	ballPhysicsTop u_ballPhysicsTop (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic checkValue(input string what, input int expected, input int actual);
		checkCount++;
		if (expected != actual) begin
			errorCount++;
			$display("MISMATCH %s %s: expected %0d, actual %0d", testName, what, expected, actual);
		end
	endtask

	// returns 1 ns after the last edge, where outputs have settled and inputs may change.
	task automatic waitCycles(input int count);
		repeat (count) @(posedge clk);
		#1;
	endtask

	task automatic beginTest(input string name);
		testName = name;
		testErrorStart = errorCount;
		testCount++;
	endtask

	task automatic endTest();
		if (errorCount == testErrorStart) begin
			$display("test %s: passed", testName);
		end else begin
			$display("test %s: %0d errors", testName, errorCount - testErrorStart);
		end
	endtask

	`include "ballPhysicsTests.svh"

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		resetN = 1'b0;
		startOfFrame = 1'b0;
		pause = 1'b0;
		levelReset = 1'b0;
		hit = '0;
		flipperSpeedX = 0;
		springSpeedY = 0;
		pixel = '0;
		repeat (5) @(posedge clk);
		#1;
		resetN = 1'b1;
		resetModel();
		freeFallAndReset();
		edgeReflection();
		springAndFlipper();
		bumperCooldown();
		pauseAndLevelReset();
		drawAndLostFlag();
		$display("summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+testbench
src/gamePkg.sv
src/collisionPkg.sv
src/collisionRouter.sv
src/ballMotion.sv
src/ballDrawMux.sv
src/ballPhysicsTop.sv
testbench/ballPhysicsTb.sv
